// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // datapath and register index widths
  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // program memory geometry
  localparam int PROG_WORDS = 64;
  localparam int PROG_ADDR_W = 6;

  // major opcodes still decoded by the core
  typedef enum logic [6:0] {
    OP_LUI     = 7'b0110111,
    OP_REG_IMM = 7'b0010011,
    OP_REG_REG = 7'b0110011,
    OP_BRANCH  = 7'b1100011,
    OP_SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_imm
  } alu_op_t;

  typedef enum logic [2:0] {
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu,
    br_none
  } br_cond_t;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_halted
  } run_state_t;

endpackage

`default_nettype wire

// ==== hdl/core_ifs.sv ====
`default_nettype none

// decoded view of the current instruction, purely combinational
interface decode_if import rv_pkg::*; ();
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  logic                  use_imm;
  alu_op_t               alu_op;
  br_cond_t              br_cond;
  logic                  wb_en;
  logic                  is_ecall;
  logic                  is_illegal;

  modport producer (
    output rs1, rs2, rd, imm, use_imm, alu_op, br_cond, wb_en, is_ecall, is_illegal
  );
  modport consumer (
    input rs1, rs2, rd, imm, use_imm, alu_op, br_cond, wb_en, is_ecall, is_illegal
  );
endinterface

// register file ports
interface rf_if import rv_pkg::*; ();
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       rd_data;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic                  we;

  modport storage (
    input  rs1, rs2, rd, rd_data, we,
    output rs1_data, rs2_data
  );
  modport user (
    input  rs1_data, rs2_data,
    output rd_data
  );
endinterface

`default_nettype wire

// ==== hdl/program_rom.sv ====
`default_nettype none

module program_rom import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   we,
  input  logic [PROG_ADDR_W-1:0] waddr,
  input  logic [XLEN-1:0]        wdata,
  input  logic [XLEN-1:0]        pc,
  output logic [XLEN-1:0]        insn
);

  logic [XLEN-1:0] mem [PROG_WORDS];

  // word writes from the load port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch by word address, byte offset dropped
  assign insn = mem[pc[PROG_ADDR_W+1:2]];

  // fetch address must land on a word boundary
  a_pc_aligned: assert property (@(posedge clk) !$isunknown(pc) |-> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/insn_decoder.sv ====
`default_nettype none

module insn_decoder import rv_pkg::*; (
  input  logic [XLEN-1:0] insn,
  decode_if.producer      dec
);

  opcode_t         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;

  assign opcode = opcode_t'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign dec.rd  = insn[11:7];
  assign dec.rs1 = insn[19:15];
  assign dec.rs2 = insn[24:20];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec.imm        = imm_i;
    dec.use_imm    = 1'b0;
    dec.alu_op     = alu_add;
    dec.br_cond    = br_none;
    dec.wb_en      = 1'b0;
    dec.is_ecall   = 1'b0;
    dec.is_illegal = 1'b0;
    case (opcode)
      OP_LUI: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_pass_imm;
        dec.wb_en   = 1'b1;
      end
      OP_REG_IMM: begin
        dec.use_imm = 1'b1;
        dec.wb_en   = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = alu_add;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b110: dec.alu_op = alu_or;
          3'b111: dec.alu_op = alu_and;
          3'b001: begin
            dec.alu_op     = alu_sll;
            dec.is_illegal = funct7 != 7'b0000000;
          end
          default: begin
            // srli and srai share funct3 and differ in funct7
            if (funct7 == 7'b0000000) begin
              dec.alu_op = alu_srl;
            end else if (funct7 == 7'b0100000) begin
              dec.alu_op = alu_sra;
            end else begin
              dec.is_illegal = 1'b1;
            end
          end
        endcase
      end
      OP_REG_REG: begin
        dec.wb_en = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  dec.alu_op = alu_add;
            3'b001:  dec.alu_op = alu_sll;
            3'b010:  dec.alu_op = alu_slt;
            3'b011:  dec.alu_op = alu_sltu;
            3'b100:  dec.alu_op = alu_xor;
            3'b101:  dec.alu_op = alu_srl;
            3'b110:  dec.alu_op = alu_or;
            default: dec.alu_op = alu_and;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.alu_op = alu_sub;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          dec.alu_op = alu_sra;
        end else begin
          dec.is_illegal = 1'b1;
        end
      end
      OP_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.br_cond = br_eq;
          3'b001:  dec.br_cond = br_ne;
          3'b100:  dec.br_cond = br_lt;
          3'b101:  dec.br_cond = br_ge;
          3'b110:  dec.br_cond = br_ltu;
          3'b111:  dec.br_cond = br_geu;
          default: dec.is_illegal = 1'b1;
        endcase
      end
      OP_SYSTEM: begin
        // only the all-zero ecall encoding is accepted
        if (insn[31:7] == 25'd0) begin
          dec.is_ecall = 1'b1;
        end else begin
          dec.is_illegal = 1'b1;
        end
      end
      default: dec.is_illegal = 1'b1;
    endcase
    // an illegal word must not write back
    if (dec.is_illegal) begin
      dec.wb_en = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file import rv_pkg::*; (
  input logic    clk,
  input logic    rst,
  rf_if.storage  rf
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && rf.rd != '0) begin
      regs[rf.rd] <= rf.rd_data;
    end
  end

  // two asynchronous read ports
  assign rf.rs1_data = regs[rf.rs1];
  assign rf.rs2_data = regs[rf.rs2];

  // x0 reads as zero no matter what was written before
  a_x0_rs1: assert property (@(posedge clk) disable iff (rst)
    rf.rs1 == '0 |-> rf.rs1_data == '0);
  a_x0_rs2: assert property (@(posedge clk) disable iff (rst)
    rf.rs2 == '0 |-> rf.rs2_data == '0);

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu import rv_pkg::*; (
  decode_if.consumer      dec,
  rf_if.user              rf,
  input  logic [XLEN-1:0] pc,
  output logic            branch_taken,
  output logic [XLEN-1:0] branch_target
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;

  assign op_a  = rf.rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rf.rs2_data;
  // shift amount comes from the low bits for both imm and reg forms
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_add:      rf.rd_data = op_a + op_b;
      alu_sub:      rf.rd_data = op_a - op_b;
      alu_sll:      rf.rd_data = op_a << shamt;
      alu_slt:      rf.rd_data = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:     rf.rd_data = {{(XLEN-1){1'b0}}, op_a < op_b};
      alu_xor:      rf.rd_data = op_a ^ op_b;
      alu_srl:      rf.rd_data = op_a >> shamt;
      alu_sra:      rf.rd_data = $signed(op_a) >>> shamt;
      alu_or:       rf.rd_data = op_a | op_b;
      alu_and:      rf.rd_data = op_a & op_b;
      default:      rf.rd_data = dec.imm;
    endcase
  end

  // branch compare always uses both registers
  always_comb begin
    case (dec.br_cond)
      br_eq:   branch_taken = rf.rs1_data == rf.rs2_data;
      br_ne:   branch_taken = rf.rs1_data != rf.rs2_data;
      br_lt:   branch_taken = $signed(rf.rs1_data) < $signed(rf.rs2_data);
      br_ge:   branch_taken = $signed(rf.rs1_data) >= $signed(rf.rs2_data);
      br_ltu:  branch_taken = rf.rs1_data < rf.rs2_data;
      br_geu:  branch_taken = rf.rs1_data >= rf.rs2_data;
      default: branch_taken = 1'b0;
    endcase
  end

  assign branch_target = pc + dec.imm;

endmodule

`default_nettype wire

// ==== hdl/pc_counter.sv ====
`default_nettype none

module pc_counter import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            clear,
  input  logic            advance,
  input  logic            branch_taken,
  input  logic [XLEN-1:0] branch_target,
  output logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] retired
);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      pc      <= '0;
      retired <= '0;
    end else if (advance) begin
      pc      <= branch_taken ? branch_target : pc + XLEN'(4);
      retired <= retired + XLEN'(1);
    end
  end

  // a taken branch with a half-word offset would break this
  a_pc_word: assert property (@(posedge clk) disable iff (rst)
    advance |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/run_control.sv ====
`default_nettype none

module run_control import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       prog_we,
  decode_if.consumer dec,
  output logic       rf_we,
  output logic       advance,
  output logic       clear,
  output logic       halt,
  output logic       illegal
);

  run_state_t state;
  run_state_t state_next;
  logic       in_run;
  logic       illegal_q;

  assign in_run = state == st_run;

  // start only counts while not already running
  assign clear = start && !in_run;

  always_comb begin
    state_next = state;
    case (state)
      st_run: begin
        if (dec.is_ecall || dec.is_illegal) begin
          state_next = st_halted;
        end
      end
      default: begin
        if (start) begin
          state_next = st_run;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      illegal_q <= 1'b0;
    end else begin
      state <= state_next;
      if (clear) begin
        illegal_q <= 1'b0;
      end else if (in_run && dec.is_illegal) begin
        illegal_q <= 1'b1;
      end
    end
  end

  assign rf_we   = in_run && dec.wb_en && dec.rd != '0;
  // illegal words do not retire
  assign advance = in_run && !dec.is_illegal;
  assign halt    = state == st_halted;
  assign illegal = illegal_q;

  a_no_load_in_run: assert property (@(posedge clk) disable iff (rst)
    state == st_run |-> !prog_we);

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   prog_we,
  input  logic [PROG_ADDR_W-1:0] prog_addr,
  input  logic [XLEN-1:0]        prog_data,
  output logic [XLEN-1:0]        pc,
  output logic [XLEN-1:0]        retired,
  output logic                   wb_valid,
  output logic [REG_ADDR_W-1:0]  wb_rd,
  output logic [XLEN-1:0]        wb_data,
  output logic                   halt,
  output logic                   illegal
);

  logic [XLEN-1:0] insn;
  logic            branch_taken;
  logic [XLEN-1:0] branch_target;
  logic            rf_we;
  logic            advance;
  logic            clear;

  decode_if dec_bus ();
  rf_if     rf_bus ();

  // register addresses and write enable into the register port bundle
  assign rf_bus.rs1 = dec_bus.rs1;
  assign rf_bus.rs2 = dec_bus.rs2;
  assign rf_bus.rd  = dec_bus.rd;
  assign rf_bus.we  = rf_we;

  // write-back stream mirrors the register write port
  assign wb_valid = rf_we;
  assign wb_rd    = rf_bus.rd;
  assign wb_data  = rf_bus.rd_data;

  program_rom u_rom (
    .clk   (clk),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .pc    (pc),
    .insn  (insn)
  );

  insn_decoder u_dec (.insn(insn), .dec(dec_bus));

  reg_file u_rf (.clk(clk), .rst(rst), .rf(rf_bus));

  alu u_alu (
    .dec           (dec_bus),
    .rf            (rf_bus),
    .pc            (pc),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  pc_counter u_pc (
    .clk           (clk),
    .rst           (rst),
    .clear         (clear),
    .advance       (advance),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .pc            (pc),
    .retired       (retired)
  );

  run_control u_ctrl (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .prog_we (prog_we),
    .dec     (dec_bus),
    .rf_we   (rf_we),
    .advance (advance),
    .clear   (clear),
    .halt    (halt),
    .illegal (illegal)
  );

endmodule

`default_nettype wire

// ==== bench/tb_rv_core.sv ====
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  logic                   clk;
  logic                   rst;
  logic                   start;
  logic                   prog_we;
  logic [PROG_ADDR_W-1:0] prog_addr;
  logic [XLEN-1:0]        prog_data;
  logic [XLEN-1:0]        pc;
  logic [XLEN-1:0]        retired;
  logic                   wb_valid;
  logic [REG_ADDR_W-1:0]  wb_rd;
  logic [XLEN-1:0]        wb_data;
  logic                   halt;
  logic                   illegal;

  // test table with one entry per E line of the pattern file
  logic [XLEN-1:0]       prog_words[$];
  int                    prog_len[$];
  logic [REG_ADDR_W-1:0] exp_rd[$];
  logic [XLEN-1:0]       exp_data[$];
  int                    wb_count[$];
  int                    exp_retired[$];
  logic                  exp_illegal[$];

  int cur_test = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  rv_core UUT (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .retired   (retired),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halt      (halt),
    .illegal   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      stop_on_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h in test %0d",
                                name, got, exp, cur_test));
    end
  endtask

  // limit armed once the pattern file is read
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      stop_on_failure($sformatf("timeout: no halt within %0d cycles", cycle_limit));
    end
  end

  task automatic read_patterns();
    int                   fd;
    int                   n;
    int                   need;
    int                   len;
    int                   wbs;
    int                   ret;
    int                   ill;
    logic [63:0]          token;
    logic [8*128-1:0]     rest;
    logic [XLEN-1:0]      word;
    logic [XLEN-1:0]      rd_word;
    fd = $fopen("bench/rv_core_patterns.txt", "r");
    if (fd == 0) begin
      stop_on_failure("cannot open the pattern file bench/rv_core_patterns.txt");
    end
    len = 0;
    wbs = 0;
    while ($fscanf(fd, "%s", token) == 1) begin
      if (token == "#") begin
        n = $fgets(rest, fd);
        need = n;
      end else if (token == "P") begin
        n = $fscanf(fd, "%h", word);
        need = 1;
        prog_words.push_back(word);
        len++;
      end else if (token == "W") begin
        n = $fscanf(fd, "%h %h", rd_word, word);
        need = 2;
        exp_rd.push_back(rd_word[REG_ADDR_W-1:0]);
        exp_data.push_back(word);
        wbs++;
      end else if (token == "E") begin
        n = $fscanf(fd, "%d %d", ret, ill);
        need = 2;
        prog_len.push_back(len);
        wb_count.push_back(wbs);
        exp_retired.push_back(ret);
        exp_illegal.push_back(ill != 0);
        len = 0;
        wbs = 0;
      end else begin
        stop_on_failure("unknown line kind in the pattern file");
      end
      if (n != need) begin
        stop_on_failure("malformed line in the pattern file");
      end
    end
    $fclose(fd);
    if (prog_len.size() == 0) begin
      stop_on_failure("the pattern file holds no complete test");
    end
  endtask

  task automatic run_test(input int t, input int word_base, input int wb_base);
    int w_idx;
    bit done;
    @(posedge clk);
    rst     <= 1'b1;
    start   <= 1'b0;
    prog_we <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // idle state after reset and before any start
    @(negedge clk);
    check_value("halt", XLEN'(halt), '0);
    check_value("illegal", XLEN'(illegal), '0);
    check_value("wb_valid", XLEN'(wb_valid), '0);
    check_value("pc", pc, '0);
    check_value("retired", retired, '0);
    for (int i = 0; i < prog_len[t]; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= PROG_ADDR_W'(i);
      prog_data <= prog_words[word_base + i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    start   <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    // one sample per run cycle at mid-cycle
    w_idx = wb_base;
    done  = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (halt) begin
        done = 1'b1;
      end else if (wb_valid) begin
        assert (w_idx < wb_base + wb_count[t]) else begin
          stop_on_failure($sformatf("test %0d wrote x%0d with no expected write-back left",
                                    t, wb_rd));
        end
        check_value("wb_rd", XLEN'(wb_rd), XLEN'(exp_rd[w_idx]));
        check_value("wb_data", wb_data, exp_data[w_idx]);
        w_idx++;
      end
    end
    assert (w_idx == wb_base + wb_count[t]) else begin
      stop_on_failure($sformatf("test %0d halted with %0d expected write-backs missing",
                                t, wb_base + wb_count[t] - w_idx));
    end
    check_value("retired", retired, XLEN'(exp_retired[t]));
    check_value("illegal", XLEN'(illegal), XLEN'(exp_illegal[t]));
    check_value("wb_valid", XLEN'(wb_valid), '0);
  endtask

  initial begin
    int word_base;
    int wb_base;
    rst       <= 1'b1;
    start     <= 1'b0;
    prog_we   <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    read_patterns();
    foreach (prog_len[t]) begin
      cycle_limit += exp_retired[t] + prog_len[t] + 20;
    end
    word_base = 0;
    wb_base   = 0;
    for (int t = 0; t < prog_len.size(); t++) begin
      cur_test = t;
      run_test(t, word_base, wb_base);
      word_base += prog_len[t];
      wb_base   += wb_count[t];
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/rv_core_patterns.txt ====
# P word: program word in hex, loaded from word address 0 upward
# W rd data: expected write-back in hex, in order; E retired illegal: ends a test
# register-immediate group, the last addi writes x0
P FFB00093
W 01 FFFFFFFB
P 0030A113
W 02 00000001
P 0030B193
W 03 00000000
P 0F00C213
W 04 FFFFFF0B
P 12306293
W 05 00000123
P 7FF0F313
W 06 000007FB
P 00429393
W 07 00001230
P 01C0D413
W 08 0000000F
P 4010D493
W 09 FFFFFFFD
P 00708013
P 00000073
E 11 0
# lui and the register-register group
P 800000B7
W 01 80000000
P 00500113
W 02 00000005
P FFD00193
W 03 FFFFFFFD
P 00310233
W 04 00000002
P 403102B3
W 05 00000008
P 00211333
W 06 000000A0
P 0021A3B3
W 07 00000001
P 0021B433
W 08 00000000
P 0030C4B3
W 09 7FFFFFFD
P 0020D533
W 0A 04000000
P 4020D5B3
W 0B FC000000
P 00316633
W 0C FFFFFFFD
P 003176B3
W 0D 00000005
P 00000073
E 14 0
# six branches taken and not taken, skipped slots hold illegal words
P 00300093
W 01 00000003
P FFF00113
W 02 FFFFFFFF
P 00208463
P 00115463
P 00116463
P 00209463
P 00000000
P 00114463
P 00000000
P 00117463
P 00000000
P FFF08093
W 01 00000002
W 01 00000001
W 01 00000000
P FE009EE3
P 00008463
P 00000000
P 0020D463
P 00000000
P 0020E463
P 00000000
P 0020C463
P 0020F463
P 00700193
W 03 00000007
P 00000073
E 21 0
# store opcode is illegal and does not retire
P 00100093
W 01 00000001
P 00112023
E 1 1

// ==== sim.f ====
hdl/rv_pkg.sv
hdl/core_ifs.sv
hdl/program_rom.sv
hdl/insn_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/pc_counter.sv
hdl/run_control.sv
hdl/rv_core.sv
bench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_rv_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
echo "pass line not found in the simulation output"
exit 1
